/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ******************************
    // widths
    // ******************************

    localparam int XLEN_DEFAULT = 32;  // operand and result width

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // ******************************
    // operation class from the requester
    // ******************************

    typedef enum logic [2:0] {
        R_TYPE    = 3'd0,
        I_TYPE    = 3'd1,
        ADD_TYPE  = 3'd2,  // address computation
        JALR_TYPE = 3'd3,
        B_TYPE    = 3'd4,
        LUI_TYPE  = 3'd5
    } op_class_t;

    // ******************************
    // ALU select codes
    // ******************************

    typedef enum logic [4:0] {
        ALU_ADD    = 5'h00,
        ALU_SUB    = 5'h01,
        ALU_SLL    = 5'h02,
        ALU_SLT    = 5'h03,
        ALU_SLTU   = 5'h04,
        ALU_XOR    = 5'h05,
        ALU_SRL    = 5'h06,
        ALU_SRA    = 5'h07,
        ALU_OR     = 5'h08,
        ALU_AND    = 5'h09,
        ALU_JALR   = 5'h0a,
        ALU_BEQ    = 5'h0b,  // branch compares return the taken flag
        ALU_BNE    = 5'h0c,
        ALU_BLT    = 5'h0d,
        ALU_BGE    = 5'h0e,
        ALU_BLTU   = 5'h0f,
        ALU_BGEU   = 5'h10,
        ALU_IMM    = 5'h11,  // operand b passed through
        ALU_MUL    = 5'h12,  // the four multiplies go to mul_unit
        ALU_MULH   = 5'h13,
        ALU_MULHSU = 5'h14,
        ALU_MULHU  = 5'h15
    } alu_sel_t;

endpackage

`default_nettype wire

/* verilog/alu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl (
    input  exec_pkg::op_class_t op_class,
    input  exec_pkg::funct3_t   funct3,
    input  exec_pkg::funct7_t   funct7,
    output exec_pkg::alu_sel_t  alu_sel
);

    import exec_pkg::*;

    logic base_op;  // funct7 is all zero
    logic m_ext;    // funct7 marks the M extension

    assign base_op = (funct7 == 7'b0000000);
    assign m_ext   = (funct7 == 7'b0000001);

    always_comb begin
        case (op_class)
            R_TYPE: begin
                case (funct3)
                    3'b000: begin
                        if (base_op) alu_sel = ALU_ADD;
                        else if (m_ext) alu_sel = ALU_MUL;
                        else alu_sel = ALU_SUB;
                    end
                    3'b001: alu_sel = base_op ? ALU_SLL : ALU_MULH;
                    3'b010: alu_sel = base_op ? ALU_SLT : ALU_MULHSU;
                    3'b011: alu_sel = base_op ? ALU_SLTU : ALU_MULHU;
                    3'b100: alu_sel = ALU_XOR;
                    3'b101: alu_sel = base_op ? ALU_SRL : ALU_SRA;
                    3'b110: alu_sel = ALU_OR;
                    default: alu_sel = ALU_AND;
                endcase
            end
            I_TYPE: begin
                case (funct3)
                    3'b000: alu_sel = ALU_ADD;
                    3'b001: alu_sel = ALU_SLL;
                    3'b010: alu_sel = ALU_SLT;
                    3'b011: alu_sel = ALU_SLTU;
                    3'b100: alu_sel = ALU_XOR;
                    3'b101: alu_sel = base_op ? ALU_SRL : ALU_SRA;  // funct7 picks the shift
                    3'b110: alu_sel = ALU_OR;
                    default: alu_sel = ALU_AND;
                endcase
            end
            ADD_TYPE: begin
                alu_sel = ALU_ADD;
            end
            JALR_TYPE: begin
                alu_sel = ALU_JALR;
            end
            B_TYPE: begin
                case (funct3)
                    3'b000: alu_sel = ALU_BEQ;
                    3'b001: alu_sel = ALU_BNE;
                    3'b100: alu_sel = ALU_BLT;
                    3'b101: alu_sel = ALU_BGE;
                    3'b110: alu_sel = ALU_BLTU;
                    default: alu_sel = ALU_BGEU;  // 010 and 011 are unused in RV32
                endcase
            end
            default: begin
                alu_sel = ALU_IMM;  // LUI and anything unknown
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu #(
    parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_en,
    input  exec_pkg::alu_sel_t alu_sel,
    input  logic [XLEN-1:0]    src_a,
    input  logic [XLEN-1:0]    src_b,
    output logic [XLEN-1:0]    alu_result
);

    import exec_pkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] next_result;
    logic [4:0]      shamt;
    logic            eq;
    logic            lt_s;
    logic            lt_u;

    assign sum   = src_a + src_b;
    assign diff  = src_a - src_b;
    assign shamt = src_b[4:0];  // only the low five bits shift
    assign eq    = (src_a == src_b);
    assign lt_s  = ($signed(src_a) < $signed(src_b));
    assign lt_u  = (src_a < src_b);

    always_comb begin
        case (alu_sel)
            ALU_ADD:  next_result = sum;
            ALU_SUB:  next_result = diff;
            ALU_SLL:  next_result = src_a << shamt;
            ALU_SLT:  next_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: next_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  next_result = src_a ^ src_b;
            ALU_SRL:  next_result = src_a >> shamt;
            ALU_SRA:  next_result = $unsigned($signed(src_a) >>> shamt);
            ALU_OR:   next_result = src_a | src_b;
            ALU_AND:  next_result = src_a & src_b;
            ALU_JALR: next_result = {sum[XLEN-1:1], 1'b0};  // target is halfword aligned
            ALU_BEQ:  next_result = {{(XLEN-1){1'b0}}, eq};
            ALU_BNE:  next_result = {{(XLEN-1){1'b0}}, !eq};
            ALU_BLT:  next_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_BGE:  next_result = {{(XLEN-1){1'b0}}, !lt_s};
            ALU_BLTU: next_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_BGEU: next_result = {{(XLEN-1){1'b0}}, !lt_u};
            ALU_IMM:  next_result = src_b;
            default:  next_result = '0;  // multiplies are not computed here
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_result <= '0;
        end else if (alu_en) begin
            alu_result <= next_result;
        end
    end

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               mul_start,
    input  exec_pkg::alu_sel_t alu_sel,
    input  logic [XLEN-1:0]    src_a,
    input  logic [XLEN-1:0]    src_b,
    output logic               mul_busy,
    output logic [XLEN-1:0]    mul_result
);

    import exec_pkg::*;

    localparam int CNT_W = $clog2(XLEN + 1);

    logic [2*XLEN-1:0] mcand;     // shifts left one place per step
    logic [2*XLEN-1:0] prod;
    logic [2*XLEN-1:0] signed_prod;
    logic [XLEN-1:0]   mplier;    // shifts right, bit 0 decides the add
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [CNT_W-1:0]  cnt;
    logic              a_neg;
    logic              b_neg;
    logic              negate;
    logic              want_high;

    // MULH treats both operands as signed, MULHSU only operand a
    assign a_neg = ((alu_sel == ALU_MULH) || (alu_sel == ALU_MULHSU)) && src_a[XLEN-1];
    assign b_neg = (alu_sel == ALU_MULH) && src_b[XLEN-1];
    assign mag_a = a_neg ? (~src_a + 1'b1) : src_a;
    assign mag_b = b_neg ? (~src_b + 1'b1) : src_b;
    assign signed_prod = negate ? (~prod + 1'b1) : prod;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_busy <= 1'b0;
            cnt <= '0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
            cnt <= '0;
        end else if (mul_busy) begin
            if (cnt == CNT_W'(XLEN)) begin
                mul_busy <= 1'b0;  // sign step done
            end
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand <= {{XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            prod <= '0;
            negate <= a_neg ^ b_neg;
            want_high <= (alu_sel != ALU_MUL);
        end else if (mul_busy) begin
            if (cnt == CNT_W'(XLEN)) begin
                mul_result <= want_high ? signed_prod[2*XLEN-1:XLEN] : signed_prod[XLEN-1:0];
            end else begin
                if (mplier[0]) begin
                    prod <= prod + mcand;
                end
                mcand <= mcand << 1;
                mplier <= mplier >> 1;
            end
        end
    end

    // the controller waits for the product before it starts another
    a_start_idle: assert property (@(posedge clk) disable iff (rst) mul_start |-> !mul_busy);

endmodule

`default_nettype wire

/* verilog/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl #(
    parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  exec_pkg::alu_sel_t alu_sel,
    input  logic [XLEN-1:0]    alu_result,
    input  logic               mul_busy,
    input  logic [XLEN-1:0]    mul_result,
    output logic               alu_en,
    output logic               mul_start,
    output logic               ack,
    output logic [XLEN-1:0]    result
);

    import exec_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ALU_RUN,
        MUL_START,
        MUL_WAIT,
        DONE,
        RELEASE
    } state_t;

    state_t state;
    logic   is_mul;

    // operands and alu_sel stay stable while req is high
    assign is_mul    = alu_sel inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    assign alu_en    = (state == ALU_RUN);
    assign mul_start = (state == MUL_START);  // one cycle, the state always moves on

    // ******************************
    // four-phase sequencing
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    ack <= 1'b0;  // falls one cycle after req is seen low
                    if (req && !ack) begin
                        state <= is_mul ? MUL_START : ALU_RUN;
                    end
                end
                ALU_RUN: state <= DONE;
                MUL_START: state <= MUL_WAIT;
                MUL_WAIT: begin
                    if (!mul_busy) begin
                        state <= DONE;
                    end
                end
                DONE: state <= RELEASE;
                RELEASE: begin
                    if (req) begin
                        ack <= 1'b1;  // held as long as req is held
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DONE) begin
            result <= is_mul ? mul_result : alu_result;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req));
    a_result_held: assert property (@(posedge clk) disable iff (rst)
        ack |=> (!ack || $stable(result)));

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  exec_pkg::op_class_t op_class,
    input  exec_pkg::funct3_t   funct3,
    input  exec_pkg::funct7_t   funct7,
    input  logic [XLEN-1:0]     src_a,
    input  logic [XLEN-1:0]     src_b,
    output logic                ack,
    output logic [XLEN-1:0]     result
);

    import exec_pkg::*;

    alu_sel_t        alu_sel;
    logic            alu_en;
    logic            mul_start;
    logic            mul_busy;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_result;

    alu_ctrl u_alu_ctrl (
        .op_class (op_class),
        .funct3   (funct3),
        .funct7   (funct7),
        .alu_sel  (alu_sel)
    );

    int_alu #(.XLEN(XLEN)) u_int_alu (
        .clk        (clk),
        .rst        (rst),
        .alu_en     (alu_en),
        .alu_sel    (alu_sel),
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_result (alu_result)
    );

    mul_unit #(.XLEN(XLEN)) u_mul_unit (
        .clk        (clk),
        .rst        (rst),
        .mul_start  (mul_start),
        .alu_sel    (alu_sel),
        .src_a      (src_a),
        .src_b      (src_b),
        .mul_busy   (mul_busy),
        .mul_result (mul_result)
    );

    exec_ctrl #(.XLEN(XLEN)) u_exec_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .alu_sel    (alu_sel),
        .alu_result (alu_result),
        .mul_busy   (mul_busy),
        .mul_result (mul_result),
        .alu_en     (alu_en),
        .mul_start  (mul_start),
        .ack        (ack),
        .result     (result)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;  // released on a rising edge like any other input
    end

endmodule

`default_nettype wire

/* testbench/tb_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;

    import exec_pkg::*;

    localparam int XLEN    = 32;
    localparam int TIMEOUT = 200;  // cycles, well above the multiply latency

    logic            clk;
    logic            rst;
    logic            req;
    op_class_t       op_class;
    funct3_t         funct3;
    funct7_t         funct7;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic            ack;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] exp_result;
    logic            mul_op;
    string           test_name;

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    exec_unit #(.XLEN(XLEN)) UUT (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .op_class (op_class),
        .funct3   (funct3),
        .funct7   (funct7),
        .src_a    (src_a),
        .src_b    (src_b),
        .ack      (ack),
        .result   (result)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ******************************
    // reference model
    // ******************************

    function automatic logic [XLEN-1:0] ref_mul(input funct3_t f3, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [63:0] wa;
        logic [63:0] wb;
        logic [63:0] prod;
        wa = {{32{a[31] && (f3 == 3'd1 || f3 == 3'd2)}}, a};  // MULH and MULHSU sign a
        wb = {{32{b[31] && (f3 == 3'd1)}}, b};
        prod = wa * wb;
        return (f3 == 3'd0) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic ref_is_mul(input op_class_t cls, input funct3_t f3,
                                        input funct7_t f7);
        return (cls == R_TYPE) && ((f3 == 3'd0 && f7 == 7'd1) ||
                                   (f3 inside {3'd1, 3'd2, 3'd3} && f7 != 7'd0));
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input op_class_t cls, input funct3_t f3,
                                                input funct7_t f7, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] res;
        logic            alt;
        alt = (f7 != 7'd0);
        res = b;  // LUI and unknown classes pass operand b
        case (cls)
            R_TYPE, I_TYPE: begin
                case (f3)
                    3'd0: res = a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = {31'd0, $signed(a) < $signed(b)};
                    3'd3: res = {31'd0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (alt) res = $unsigned($signed(a) >>> b[4:0]);
                        else res = a >> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
                if (ref_is_mul(cls, f3, f7)) res = ref_mul(f3, a, b);
                else if (cls == R_TYPE && f3 == 3'd0 && alt) res = a - b;
            end
            B_TYPE: begin
                case (f3)
                    3'd0: res = {31'd0, a == b};
                    3'd1: res = {31'd0, a != b};
                    3'd4: res = {31'd0, $signed(a) < $signed(b)};
                    3'd5: res = {31'd0, $signed(a) >= $signed(b)};
                    3'd6: res = {31'd0, a < b};
                    default: res = {31'd0, a >= b};
                endcase
            end
            ADD_TYPE: res = a + b;
            JALR_TYPE: res = (a + b) & ~32'd1;
            default: res = b;
        endcase
        return res;
    endfunction

    // ******************************
    // checks
    // ******************************

    a_reset_ack: assert property (@(posedge clk) rst |=> !ack)
        else abort_run("ack was not low after a reset cycle");
    a_result_ok: assert property (@(posedge clk) disable iff (rst) ack |-> result == exp_result)
        else abort_run($sformatf("Error: %s expected %h actual %h", test_name, exp_result,
                                 $sampled(result)));
    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        ack && $past(ack) |-> $stable(result))
        else abort_run("result changed while ack was high");
    a_ack_with_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else abort_run("ack rose while req was low");
    a_ack_held: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
        else abort_run("ack dropped while req was still held");
    a_ack_release: assert property (@(posedge clk) disable iff (rst)
        $fell(req) |-> ack ##1 ack ##1 !ack)
        else abort_run("ack did not fall one cycle after req was seen low");
    // sampled ack lags its edge by one, so a 3 cycle latency shows up at the fourth sample
    a_alu_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(req) && !mul_op |-> ##3 !ack ##1 ack)
        else abort_run("non-multiply ack did not arrive 3 cycles after req");

    // ******************************
    // stimulus
    // ******************************

    task automatic run_op(input string name, input op_class_t cls, input funct3_t f3,
                          input funct7_t f7, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input int hold);
        int waited;
        @(posedge clk);
        test_name  <= name;
        exp_result <= ref_alu(cls, f3, f7, a, b);
        mul_op     <= ref_is_mul(cls, f3, f7);
        op_class   <= cls;
        funct3     <= f3;
        funct7     <= f7;
        src_a      <= a;
        src_b      <= b;
        req        <= 1'b1;
        waited = 0;
        while (ack !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run($sformatf("ack never rose during %s", name));
        end
        repeat (hold) @(posedge clk);  // back-pressure, req stays high
        req <= 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run($sformatf("ack never fell after %s", name));
        end
    endtask

    task automatic run_group(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        funct3_t br_codes [6];
        br_codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int f = 0; f < 8; f++) begin
            run_op($sformatf("r_type f3=%0d", f), R_TYPE, funct3_t'(f), 7'h00, a, b, 0);
            run_op($sformatf("i_type f3=%0d", f), I_TYPE, funct3_t'(f), 7'h00, a, b, 0);
        end
        for (int f = 0; f < 4; f++) begin
            run_op($sformatf("m_ext f3=%0d", f), R_TYPE, funct3_t'(f), 7'h01, a, b, 0);
        end
        run_op("r_type sub", R_TYPE, 3'd0, 7'h20, a, b, 0);
        run_op("r_type sra", R_TYPE, 3'd5, 7'h20, a, b, 0);
        run_op("i_type srai", I_TYPE, 3'd5, 7'h20, a, b, 0);
        foreach (br_codes[k]) begin
            run_op($sformatf("branch f3=%0d", br_codes[k]), B_TYPE, br_codes[k], 7'h00, a, b, 0);
        end
        run_op("add_type", ADD_TYPE, 3'd0, 7'h00, a, b, 0);
        run_op("jalr_type", JALR_TYPE, 3'd0, 7'h00, a, b, 0);
        run_op("lui_type", LUI_TYPE, 3'd0, 7'h00, a, b, 0);
    endtask

    initial begin
        logic [XLEN-1:0] edge_vals [5];
        int              waited;
        edge_vals = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000,
                      32'hffff_ffff};
        req = 1'b0;
        op_class = R_TYPE;
        funct3 = '0;
        funct7 = '0;
        src_a = '0;
        src_b = '0;
        exp_result = '0;
        mul_op = 1'b0;
        test_name = "reset";
        void'($urandom(32'ha085_a658));
        waited = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("reset was never released");
        end
        foreach (edge_vals[i]) begin
            foreach (edge_vals[j]) run_group(edge_vals[i], edge_vals[j]);
        end
        repeat (20) run_group($urandom, $urandom);
        run_op("alu hold", R_TYPE, 3'd0, 7'h00, $urandom, $urandom, 10);
        run_op("mul hold", R_TYPE, 3'd1, 7'h01, $urandom, $urandom, 10);
        repeat (5) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/exec_pkg.sv
verilog/alu_ctrl.sv
verilog/int_alu.sv
verilog/mul_unit.sv
verilog/exec_ctrl.sv
verilog/exec_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_exec_unit.sv
